// File: perint_soc.f
hdl/pi1_pkg.sv
hdl/soc_cfg_pkg.sv
hdl/rst_ctrl.sv
hdl/pi1_decoder.sv
hdl/devtbl.sv
hdl/gpio.sv
hdl/activity_led.sv
hdl/perint_soc.sv
tests/perint_soc_tb.sv

// File: Bender.yml
package:
  name: perint_soc

sources:
  - hdl/pi1_pkg.sv
  - hdl/soc_cfg_pkg.sv
  - hdl/rst_ctrl.sv
  - hdl/pi1_decoder.sv
  - hdl/devtbl.sv
  - hdl/gpio.sv
  - hdl/activity_led.sv
  - hdl/perint_soc.sv
  - target: test
    files:
      - tests/perint_soc_tb.sv

// File: tests/perint_soc_tb.sv
// Acts as the only bus master; expects the DUT built with RST_CNTR_W and ACTIVITY_CNTR_W of 4.
`timescale 1ns/100ps

module perint_soc_tb;

	localparam int GPIO_N = 16;
	localparam int RST_W = 4;
	localparam int ACT_W = 4;
	localparam int RST_CYCLES = (1 << RST_W) - 1;
	localparam int DEAD_CYCLES = (1 << ACT_W) - 1;
	// Cycle budgets of the six tests, in order.
	localparam int BUDGET = 40 + 60 + 60 + 120 + 120 + 120;
	localparam int TIMEOUT = 2 * BUDGET;

	logic              clk100mhz_i;
	logic              rst_p;
	pi1_pkg::pi1_op_e  pi1_op;
	logic [7:0]        pi1_addr;
	logic [31:0]       pi1_wdata;
	logic [3:0]        pi1_sel;
	logic [31:0]       pi1_rdata;
	logic              pi1_rdy;
	logic [GPIO_N-1:0] gp_in;
	logic [GPIO_N-1:0] gp_out;
	logic              activity;
	logic              sys_rst;

	// Reference model state.
	logic [31:0]       lfsr_q;
	logic [GPIO_N-1:0] model_out;
	logic [GPIO_N-1:0] model_flags;
	logic [GPIO_N-1:0] model_gpi;
	logic              pend;
	logic [31:0]       pend_rd;
	logic [7:0]        pend_addr;
	logic [GPIO_N-1:0] pend_gpo;
	int                act_cnt;
	int                act_exp;
	int                act_seen;
	int                errors;
	int                errs_mark;
	int                checks;
	int                tests_run;
	int                tests_failed;
	int                cycles;

	perint_soc #(
		.GPIO_COUNT      (GPIO_N),
		.RST_CNTR_W      (RST_W),
		.ACTIVITY_CNTR_W (ACT_W)
	) i_dut (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.pi1_op_i    (pi1_op),
		.pi1_addr_i  (pi1_addr),
		.pi1_data_i  (pi1_wdata),
		.pi1_sel_i   (pi1_sel),
		.pi1_data_o  (pi1_rdata),
		.pi1_rdy_o   (pi1_rdy),
		.gp_i        (gp_in),
		.gp_o        (gp_out),
		.activity_o  (activity),
		.sys_rst_o   (sys_rst)
	);

	always #5 clk100mhz_i = ~clk100mhz_i;

	always @(posedge clk100mhz_i) begin
		cycles <= cycles + 1;
	end

	// Every flash lasts one cycle, so each high sample is one pulse.
	always @(negedge clk100mhz_i) begin
		if (activity === 1'b1) begin
			act_seen <= act_seen + 1;
		end
	end

	initial begin
		while (cycles < TIMEOUT) begin
			@(posedge clk100mhz_i);
		end
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT);
		$display("TB FAILED");
		$finish;
	end

	// Taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		rand_bits = r;
	endfunction

	function automatic logic [GPIO_N-1:0] lane_bits(input logic [3:0] sel);
		logic [GPIO_N-1:0] r;
		for (int b = 0; b < GPIO_N / 8; b++) begin
			r[b*8 +: 8] = {8{sel[b]}};
		end
		lane_bits = r;
	endfunction

	function automatic logic [GPIO_N-1:0] lane_merge(input logic [GPIO_N-1:0] old,
			input logic [31:0] data, input logic [3:0] sel);
		lane_merge = (old & ~lane_bits(sel)) | (data[GPIO_N-1:0] & lane_bits(sel));
	endfunction

	// Slot IDs and sizes in pairs, then the SoC ID in word 14.
	function automatic logic [31:0] devtbl_word(input int w);
		case (w)
			0: devtbl_word = 32'd7;
			1: devtbl_word = 32'd16;
			2: devtbl_word = 32'd6;
			3: devtbl_word = 32'd4;
			5: devtbl_word = 32'd64;
			14: devtbl_word = 32'd2;
			default: devtbl_word = 32'd0;
		endcase
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
		end
	endtask

	// Response of the previous request, plus one step of the activity model.
	task automatic check_response();
		compare($sformatf("ready after word %0d", pend_addr), {31'b0, pi1_rdy}, {31'b0, pend});
		if (pend) begin
			compare($sformatf("read data of word %0d", pend_addr), pi1_rdata, pend_rd);
		end
		compare("gp_o", {16'b0, gp_out}, {16'b0, pend_gpo});
		if (act_cnt != 0) begin
			act_cnt--;
		end else if (pend) begin
			act_cnt = DEAD_CYCLES;
			act_exp++;
		end
	endtask

	task automatic bus_req(input pi1_pkg::pi1_op_e op, input logic [7:0] addr,
			input logic [31:0] data, input logic [3:0] sel, input logic [31:0] exp_rd,
			input logic acc);
		@(posedge clk100mhz_i);
		pi1_op <= op;
		pi1_addr <= addr;
		pi1_wdata <= data;
		pi1_sel <= sel;
		@(negedge clk100mhz_i);
		check_response();
		pend = acc;
		pend_rd = exp_rd;
		pend_addr = addr;
		pend_gpo = model_out;
	endtask

	task automatic bus_idle();
		bus_req(pi1_pkg::PI1_NONE, 8'd0, 32'd0, 4'd0, 32'd0, 1'b0);
	endtask

	task automatic pulse_reset();
		@(posedge clk100mhz_i);
		rst_p <= 1'b1;
		repeat (3) @(posedge clk100mhz_i);
		rst_p <= 1'b0;
		@(negedge clk100mhz_i);
		model_out = '0;
		model_flags = '0;
		pend = 1'b0;
		pend_gpo = '0;
		act_cnt = 0;
	endtask

	// Starts at a negedge and counts the cycles with the system reset still high.
	task automatic measure_reset(input logic quiet, output int n);
		n = 0;
		while (sys_rst === 1'b1 && n < 100) begin
			if (quiet) begin
				compare("ready during reset", {31'b0, pi1_rdy}, 32'd0);
				compare("gp_o during reset", {16'b0, gp_out}, 32'd0);
				compare("activity during reset", {31'b0, activity}, 32'd0);
			end
			n++;
			@(negedge clk100mhz_i);
		end
		compare("sys_rst_o after release", {31'b0, sys_rst}, 32'd0);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != errs_mark) begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errs_mark);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		errs_mark = errors;
	endtask

	initial begin : main
		int                n;
		int                snap;
		logic [31:0]       d;
		logic [31:0]       e;
		logic [3:0]        s;
		logic [1:0]        c;
		logic [7:0]        a;
		logic [GPIO_N-1:0] v;
		pi1_pkg::pi1_op_e  op;

		clk100mhz_i = 1'b0;
		rst_p = 1'b1;
		pi1_op = pi1_pkg::PI1_NONE;
		pi1_addr = '0;
		pi1_wdata = '0;
		pi1_sel = '0;
		gp_in = '0;
		lfsr_q = 32'had85;
		model_gpi = '0;
		model_out = '0;
		model_flags = '0;
		pend = 1'b0;
		pend_rd = '0;
		pend_addr = '0;
		pend_gpo = '0;
		act_cnt = 0;
		act_exp = 0;
		act_seen = 0;
		errors = 0;
		errs_mark = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;

		pulse_reset();
		measure_reset(1'b1, n);
		compare("reset release cycles", n, RST_CYCLES);
		finish_test("reset release");

		// Back-to-back sweep, then random words with random gaps.
		for (int w = 0; w < 16; w++) begin
			bus_req(pi1_pkg::PI1_RDONLY, 8'(w), rand_bits(32), rand_bits(4), devtbl_word(w), 1'b1);
		end
		for (int i = 0; i < 16; i++) begin
			a = 8'(rand_bits(4));
			bus_req(pi1_pkg::PI1_RDONLY, a, rand_bits(32), 4'hf, devtbl_word(a), 1'b1);
			if (rand_bits(1)) begin
				bus_idle();
			end
		end
		bus_idle();
		finish_test("device table");

		for (int i = 0; i < 40; i++) begin
			d = rand_bits(32);
			s = rand_bits(4);
			op = rand_bits(1) ? pi1_pkg::PI1_RDWR : pi1_pkg::PI1_WRONLY;
			e = (op == pi1_pkg::PI1_RDWR) ? {16'b0, model_out} : 32'd0;
			model_out = lane_merge(model_out, d, s);
			bus_req(op, 8'd17, d, s, e, 1'b1);
		end
		bus_req(pi1_pkg::PI1_RDONLY, 8'd17, 32'd0, 4'hf, {16'b0, model_out}, 1'b1);
		bus_idle();
		finish_test("gpio output");

		for (int i = 0; i < 12; i++) begin
			v = rand_bits(GPIO_N);
			model_flags = model_flags | (model_gpi ^ v);
			model_gpi = v;
			@(posedge clk100mhz_i);
			gp_in <= v;
			@(negedge clk100mhz_i);
			repeat (3) bus_idle();
			bus_req(pi1_pkg::PI1_RDONLY, 8'd16, 32'd0, 4'hf, {16'b0, v}, 1'b1);
			bus_req(pi1_pkg::PI1_RDONLY, 8'd18, 32'd0, 4'hf, {16'b0, model_flags}, 1'b1);
			if (i == 5) begin
				// Partial clear under random byte lanes.
				d = rand_bits(32);
				s = rand_bits(4);
				model_flags = model_flags & ~(d[GPIO_N-1:0] & lane_bits(s));
				bus_req(pi1_pkg::PI1_WRONLY, 8'd18, d, s, 32'd0, 1'b1);
				bus_req(pi1_pkg::PI1_RDONLY, 8'd18, 32'd0, 4'hf, {16'b0, model_flags}, 1'b1);
			end
			bus_idle();
		end
		model_flags = '0;
		bus_req(pi1_pkg::PI1_WRONLY, 8'd18, 32'hffff_ffff, 4'hf, 32'd0, 1'b1);
		bus_req(pi1_pkg::PI1_RDONLY, 8'd18, 32'd0, 4'hf, 32'd0, 1'b1);
		bus_idle();
		finish_test("gpio input");

		repeat (20) bus_idle();
		act_cnt = 0;
		act_exp = 0;
		snap = act_seen;
		for (int i = 0; i < 60; i++) begin
			if (rand_bits(1)) begin
				a = 8'd20 + 8'(rand_bits(8) % 236);
				c = rand_bits(2);
				op = (c == 2'b00) ? pi1_pkg::PI1_RDONLY : pi1_pkg::pi1_op_e'(c);
				bus_req(op, a, rand_bits(32), rand_bits(4), 32'd0, 1'b1);
			end else begin
				bus_idle();
			end
		end
		repeat (20) bus_idle();
		compare("activity pulse count", act_seen - snap, act_exp);
		bus_req(pi1_pkg::PI1_RDONLY, 8'd17, 32'd0, 4'hf, {16'b0, model_out}, 1'b1);
		bus_req(pi1_pkg::PI1_RDONLY, 8'd18, 32'd0, 4'hf, {16'b0, model_flags}, 1'b1);
		bus_req(pi1_pkg::PI1_RDONLY, 8'd15, 32'd0, 4'hf, 32'd0, 1'b1);
		bus_req(pi1_pkg::PI1_RDONLY, 8'd0, 32'd0, 4'hf, devtbl_word(0), 1'b1);
		bus_idle();
		finish_test("invalid slot");

		// Warm reset with a known pattern on the outputs.
		model_out = 16'h5ac3;
		bus_req(pi1_pkg::PI1_WRONLY, 8'd17, 32'h5ac3, 4'hf, 32'd0, 1'b1);
		bus_idle();
		bus_req(pi1_pkg::PI1_WRONLY, 8'd15, 32'd2, 4'h1, 32'd0, 1'b1);
		model_out = '0;
		model_flags = '0;
		bus_idle();
		measure_reset(1'b0, n);
		// The request cycle itself, then the stretch.
		compare("warm reset cycles", n, RST_CYCLES + 1);
		bus_idle();
		bus_req(pi1_pkg::PI1_RDONLY, 8'd15, 32'd0, 4'hf, 32'd0, 1'b1);
		bus_idle();

		// Power-off holds until a fresh external reset.
		bus_req(pi1_pkg::PI1_WRONLY, 8'd15, 32'd1, 4'h1, 32'd0, 1'b1);
		bus_idle();
		bus_req(pi1_pkg::PI1_RDONLY, 8'd0, 32'd0, 4'hf, 32'd0, 1'b0);
		bus_idle();
		n = 0;
		repeat (30) begin
			@(negedge clk100mhz_i);
			if (sys_rst === 1'b1) begin
				n++;
			end
		end
		compare("cycles held in power-off", n, 30);
		pulse_reset();
		measure_reset(1'b1, n);
		compare("release after power-off", n, RST_CYCLES);
		bus_req(pi1_pkg::PI1_RDONLY, 8'd15, 32'd0, 4'hf, 32'd0, 1'b1);
		bus_idle();
		finish_test("software reset");

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: hdl/perint_soc.sv
// The bus master sits outside this level; requests during sys_rst_o are dropped without a ready.
`timescale 1ns/100ps

module perint_soc #(
	parameter int GPIO_COUNT = 16,
	parameter int RST_CNTR_W = 16,
	parameter int ACTIVITY_CNTR_W = 7
) (
	input  logic                         clk100mhz_i,
	input  logic                         rst_p,
	input  pi1_pkg::pi1_op_e             pi1_op_i,
	input  logic [pi1_pkg::ADDR_W-1:0]   pi1_addr_i,
	input  logic [pi1_pkg::ARCH_W-1:0]   pi1_data_i,
	input  logic [pi1_pkg::SEL_W-1:0]    pi1_sel_i,
	output logic [pi1_pkg::ARCH_W-1:0]   pi1_data_o,
	output logic                         pi1_rdy_o,
	input  logic [GPIO_COUNT-1:0]        gp_i,
	output logic [GPIO_COUNT-1:0]        gp_o,
	output logic                         activity_o,
	output logic                         sys_rst_o
);

	// Device table port.
	pi1_pkg::pi1_op_e            dt_op;
	logic [3:0]                  dt_addr;
	logic [pi1_pkg::ARCH_W-1:0]  dt_wdata;
	logic [pi1_pkg::SEL_W-1:0]   dt_sel;
	logic [pi1_pkg::ARCH_W-1:0]  dt_rdata;
	logic                        dt_rdy;

	// GPIO port.
	pi1_pkg::pi1_op_e            gp_op;
	logic [3:0]                  gp_addr;
	logic [pi1_pkg::ARCH_W-1:0]  gp_wdata;
	logic [pi1_pkg::SEL_W-1:0]   gp_sel;
	logic [pi1_pkg::ARCH_W-1:0]  gp_rdata;
	logic                        gp_rdy;

	logic                        rst0;
	logic                        rst1;
	logic                        req_seen;

	rst_ctrl #(
		.RST_CNTR_W (RST_CNTR_W)
	) i_rst_ctrl (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.rst0_i      (rst0),
		.rst1_i      (rst1),
		.sys_rst_o   (sys_rst_o)
	);

	pi1_decoder i_pi1_decoder (
		.clk100mhz_i   (clk100mhz_i),
		.sys_rst_i     (sys_rst_o),
		.pi1_op_i      (pi1_op_i),
		.pi1_addr_i    (pi1_addr_i),
		.pi1_data_i    (pi1_data_i),
		.pi1_sel_i     (pi1_sel_i),
		.pi1_data_o    (pi1_data_o),
		.pi1_rdy_o     (pi1_rdy_o),
		.req_seen_o    (req_seen),
		.dt_slv_op_o   (dt_op),
		.dt_slv_addr_o (dt_addr),
		.dt_slv_data_o (dt_wdata),
		.dt_slv_sel_o  (dt_sel),
		.dt_slv_data_i (dt_rdata),
		.dt_slv_rdy_i  (dt_rdy),
		.gp_slv_op_o   (gp_op),
		.gp_slv_addr_o (gp_addr),
		.gp_slv_data_o (gp_wdata),
		.gp_slv_sel_o  (gp_sel),
		.gp_slv_data_i (gp_rdata),
		.gp_slv_rdy_i  (gp_rdy)
	);

	devtbl i_devtbl (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst_o),
		.slv_op_i    (dt_op),
		.slv_addr_i  (dt_addr),
		.slv_data_i  (dt_wdata),
		.slv_sel_i   (dt_sel),
		.slv_data_o  (dt_rdata),
		.slv_rdy_o   (dt_rdy),
		.rst0_o      (rst0),
		.rst1_o      (rst1)
	);

	gpio #(
		.GPIO_COUNT (GPIO_COUNT)
	) i_gpio (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst_o),
		.slv_op_i    (gp_op),
		.slv_addr_i  (gp_addr),
		.slv_data_i  (gp_wdata),
		.slv_sel_i   (gp_sel),
		.slv_data_o  (gp_rdata),
		.slv_rdy_o   (gp_rdy),
		.gp_i        (gp_i),
		.gp_o        (gp_o)
	);

	activity_led #(
		.ACTIVITY_CNTR_W (ACTIVITY_CNTR_W)
	) i_activity_led (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst_o),
		.req_seen_i  (req_seen),
		.activity_o  (activity_o)
	);

endmodule

// File: hdl/activity_led.sv
// One short flash per burst; requests during the dead time after a flash are not counted.
`timescale 1ns/100ps

module activity_led #(
	parameter int ACTIVITY_CNTR_W = 7
) (
	input  logic clk100mhz_i,
	input  logic sys_rst_i,
	input  logic req_seen_i,
	output logic activity_o
);

	logic [ACTIVITY_CNTR_W-1:0] cntr_q;
	logic                       activity_q;

	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			cntr_q <= '0;
			activity_q <= 1'b0;
		end else if (cntr_q != '0) begin
			// Dead time keeps the indicator dim.
			cntr_q <= cntr_q - 1'b1;
			activity_q <= 1'b0;
		end else if (req_seen_i) begin
			cntr_q <= '1;
			activity_q <= 1'b1;
		end else begin
			activity_q <= 1'b0;
		end
	end

	assign activity_o = activity_q;

endmodule

// File: hdl/gpio.sv
// GPIO_COUNT must not exceed 32; inputs are asynchronous and pass two sync stages.
`timescale 1ns/100ps

module gpio #(
	parameter int GPIO_COUNT = 16
) (
	input  logic                         clk100mhz_i,
	input  logic                         sys_rst_i,
	input  pi1_pkg::pi1_op_e             slv_op_i,
	input  logic [3:0]                   slv_addr_i,
	input  logic [pi1_pkg::ARCH_W-1:0]   slv_data_i,
	input  logic [pi1_pkg::SEL_W-1:0]    slv_sel_i,
	output logic [pi1_pkg::ARCH_W-1:0]   slv_data_o,
	output logic                         slv_rdy_o,
	input  logic [GPIO_COUNT-1:0]        gp_i,
	output logic [GPIO_COUNT-1:0]        gp_o
);

	logic [GPIO_COUNT-1:0]       sync1_q;
	logic [GPIO_COUNT-1:0]       sync2_q;
	logic [GPIO_COUNT-1:0]       prev_q;
	logic [GPIO_COUNT-1:0]       out_q;
	logic [GPIO_COUNT-1:0]       chg_q;
	logic [pi1_pkg::ARCH_W-1:0]  lane_mask;
	logic [pi1_pkg::ARCH_W-1:0]  rd_word;
	logic [pi1_pkg::ARCH_W-1:0]  data_q;
	logic                        rdy_q;
	logic                        rd_en;
	logic                        wr_en;

	assign rd_en = (slv_op_i == pi1_pkg::PI1_RDONLY) || (slv_op_i == pi1_pkg::PI1_RDWR);
	assign wr_en = (slv_op_i == pi1_pkg::PI1_WRONLY) || (slv_op_i == pi1_pkg::PI1_RDWR);

	// Byte enables widened to bit enables.
	always_comb begin
		for (int b = 0; b < pi1_pkg::SEL_W; b++) begin
			lane_mask[b*8 +: 8] = {8{slv_sel_i[b]}};
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
		// Tracks through reset so that stable inputs raise no flags.
		prev_q <= sync2_q;
	end

	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			out_q <= '0;
			chg_q <= '0;
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= (slv_op_i != pi1_pkg::PI1_NONE);
			if (wr_en && slv_addr_i == 4'd1) begin
				out_q <= (out_q & ~lane_mask[GPIO_COUNT-1:0]) |
					(slv_data_i[GPIO_COUNT-1:0] & lane_mask[GPIO_COUNT-1:0]);
			end
			// A new change wins over a clear in the same cycle.
			if (wr_en && slv_addr_i == 4'd2) begin
				chg_q <= (chg_q & ~(slv_data_i[GPIO_COUNT-1:0] & lane_mask[GPIO_COUNT-1:0])) |
					(sync2_q ^ prev_q);
			end else begin
				chg_q <= chg_q | (sync2_q ^ prev_q);
			end
		end
	end

	always_comb begin
		rd_word = '0;
		case (slv_addr_i)
			4'd0: rd_word[GPIO_COUNT-1:0] = sync2_q;
			4'd1: rd_word[GPIO_COUNT-1:0] = out_q;
			4'd2: rd_word[GPIO_COUNT-1:0] = chg_q;
			default: rd_word = '0;
		endcase
	end

	// Sampled before the write lands, so read-write sees the old word.
	always_ff @(posedge clk100mhz_i) begin
		data_q <= rd_en ? rd_word : '0;
	end

	assign slv_data_o = data_q;
	assign slv_rdy_o = rdy_q;
	assign gp_o = out_q;

endmodule

// File: hdl/devtbl.sv
// Word 2i holds the ID of slot i, word 2i+1 its size; reset bits live in word 15, byte lane 0.
`timescale 1ns/100ps

module devtbl (
	input  logic                         clk100mhz_i,
	input  logic                         sys_rst_i,
	input  pi1_pkg::pi1_op_e             slv_op_i,
	input  logic [3:0]                   slv_addr_i,
	input  logic [pi1_pkg::ARCH_W-1:0]   slv_data_i,
	input  logic [pi1_pkg::SEL_W-1:0]    slv_sel_i,
	output logic [pi1_pkg::ARCH_W-1:0]   slv_data_o,
	output logic                         slv_rdy_o,
	output logic                         rst0_o,
	output logic                         rst1_o
);

	// No slot in this system raises interrupts.
	localparam logic [soc_cfg_pkg::SLOT_COUNT-1:0] USE_INTR = '0;

	soc_cfg_pkg::slot_e              slot_sel;
	logic [pi1_pkg::ARCH_W-1:0]      rd_word;
	logic [pi1_pkg::ARCH_W-1:0]      data_q;
	logic                            rdy_q;
	logic                            rst0_q;
	logic                            rst1_q;
	logic                            rd_en;
	logic                            wr_en;

	assign rd_en = (slv_op_i == pi1_pkg::PI1_RDONLY) || (slv_op_i == pi1_pkg::PI1_RDWR);
	assign wr_en = (slv_op_i == pi1_pkg::PI1_WRONLY) || (slv_op_i == pi1_pkg::PI1_RDWR);

	// Pairs of words per slot.
	assign slot_sel = soc_cfg_pkg::slot_e'(slv_addr_i[2:1]);

	always_comb begin
		rd_word = '0;
		if (slv_addr_i == soc_cfg_pkg::RST_CTRL_WORD) begin
			rd_word[1:0] = {rst1_q, rst0_q};
		end else if (slv_addr_i == soc_cfg_pkg::SOC_ID_WORD) begin
			rd_word = soc_cfg_pkg::SOC_ID;
		end else if (slv_addr_i[3:1] < soc_cfg_pkg::SLOT_COUNT) begin
			if (slv_addr_i[0]) begin
				rd_word = {USE_INTR[slot_sel],
					{(pi1_pkg::ARCH_W - 1 - pi1_pkg::ADDR_W){1'b0}},
					soc_cfg_pkg::slot_words(slot_sel)};
			end else begin
				rd_word = soc_cfg_pkg::slot_id(slot_sel);
			end
		end
	end

	// Control side.
	// The reset bits clear as soon as the system reset they request is seen.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
			rst0_q <= 1'b0;
			rst1_q <= 1'b0;
		end else begin
			rdy_q <= (slv_op_i != pi1_pkg::PI1_NONE);
			if (wr_en && slv_sel_i[0] && slv_addr_i == soc_cfg_pkg::RST_CTRL_WORD) begin
				rst0_q <= slv_data_i[0];
				rst1_q <= slv_data_i[1];
			end
		end
	end

	// Read data, zero for write-only requests.
	always_ff @(posedge clk100mhz_i) begin
		data_q <= rd_en ? rd_word : '0;
	end

	assign slv_data_o = data_q;
	assign slv_rdy_o = rdy_q;
	assign rst0_o = rst0_q;
	assign rst1_o = rst1_q;

endmodule

// File: hdl/pi1_decoder.sv
// One master only; slaves never stall, and the invalid slot is answered here with zero data.
`timescale 1ns/100ps

module pi1_decoder (
	input  logic                         clk100mhz_i,
	input  logic                         sys_rst_i,
	input  pi1_pkg::pi1_op_e             pi1_op_i,
	input  logic [pi1_pkg::ADDR_W-1:0]   pi1_addr_i,
	input  logic [pi1_pkg::ARCH_W-1:0]   pi1_data_i,
	input  logic [pi1_pkg::SEL_W-1:0]    pi1_sel_i,
	output logic [pi1_pkg::ARCH_W-1:0]   pi1_data_o,
	output logic                         pi1_rdy_o,
	output logic                         req_seen_o,
	output pi1_pkg::pi1_op_e             dt_slv_op_o,
	output logic [3:0]                   dt_slv_addr_o,
	output logic [pi1_pkg::ARCH_W-1:0]   dt_slv_data_o,
	output logic [pi1_pkg::SEL_W-1:0]    dt_slv_sel_o,
	input  logic [pi1_pkg::ARCH_W-1:0]   dt_slv_data_i,
	input  logic                         dt_slv_rdy_i,
	output pi1_pkg::pi1_op_e             gp_slv_op_o,
	output logic [3:0]                   gp_slv_addr_o,
	output logic [pi1_pkg::ARCH_W-1:0]   gp_slv_data_o,
	output logic [pi1_pkg::SEL_W-1:0]    gp_slv_sel_o,
	input  logic [pi1_pkg::ARCH_W-1:0]   gp_slv_data_i,
	input  logic                         gp_slv_rdy_i
);

	soc_cfg_pkg::slot_e slot_d;
	soc_cfg_pkg::slot_e slot_q;
	logic               req_q;

	// Address compare against the map.
	always_comb begin
		slot_d = soc_cfg_pkg::SLOT_INVALID;
		if (pi1_addr_i >= soc_cfg_pkg::DEVTBL_BASE &&
				pi1_addr_i < soc_cfg_pkg::DEVTBL_BASE + soc_cfg_pkg::DEVTBL_WORDS) begin
			slot_d = soc_cfg_pkg::SLOT_DEVTBL;
		end else if (pi1_addr_i >= soc_cfg_pkg::GPIO_BASE &&
				pi1_addr_i < soc_cfg_pkg::GPIO_BASE + soc_cfg_pkg::GPIO_WORDS) begin
			slot_d = soc_cfg_pkg::SLOT_GPIO;
		end
	end

	// Only the selected slave sees the op, the rest see an idle bus.
	assign dt_slv_op_o = (slot_d == soc_cfg_pkg::SLOT_DEVTBL) ? pi1_op_i : pi1_pkg::PI1_NONE;
	assign gp_slv_op_o = (slot_d == soc_cfg_pkg::SLOT_GPIO) ? pi1_op_i : pi1_pkg::PI1_NONE;

	assign dt_slv_addr_o = 4'(pi1_addr_i - soc_cfg_pkg::DEVTBL_BASE);
	assign gp_slv_addr_o = 4'(pi1_addr_i - soc_cfg_pkg::GPIO_BASE);

	assign dt_slv_data_o = pi1_data_i;
	assign dt_slv_sel_o = pi1_sel_i;
	assign gp_slv_data_o = pi1_data_i;
	assign gp_slv_sel_o = pi1_sel_i;

	// Remember where the answer will come from in the next cycle.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			slot_q <= soc_cfg_pkg::SLOT_INVALID;
			req_q <= 1'b0;
		end else begin
			slot_q <= slot_d;
			req_q <= (pi1_op_i != pi1_pkg::PI1_NONE);
		end
	end

	// Response return.
	// The invalid slot reads as zero and acks every request it was given.
	always_comb begin
		case (slot_q)
			soc_cfg_pkg::SLOT_DEVTBL: begin
				pi1_data_o = dt_slv_data_i;
				pi1_rdy_o = dt_slv_rdy_i;
			end
			soc_cfg_pkg::SLOT_GPIO: begin
				pi1_data_o = gp_slv_data_i;
				pi1_rdy_o = gp_slv_rdy_i;
			end
			default: begin
				pi1_data_o = '0;
				pi1_rdy_o = req_q;
			end
		endcase
	end

	assign req_seen_o = req_q;

endmodule

// File: hdl/rst_ctrl.sv
// Cold reset behaves as warm reset; power-off keeps the system in reset until the next rst_p.
`timescale 1ns/100ps

module rst_ctrl #(
	parameter int RST_CNTR_W = 16
) (
	input  logic clk100mhz_i,
	input  logic rst_p,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic sys_rst_o
);

	logic [RST_CNTR_W-1:0] cntr_q;
	logic                  pwroff_q;
	logic                  warm_req;
	logic                  pwroff_req;

	// Both the warm and the cold encoding have rst1 set.
	assign warm_req = rst1_i;
	assign pwroff_req = rst0_i & ~rst1_i;

	// Stretch counter, reloaded while a reset source is active.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || warm_req) begin
			cntr_q <= '1;
		end else if (cntr_q != '0) begin
			cntr_q <= cntr_q - 1'b1;
		end
	end

	// Only an external reset can leave the power-off state.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (pwroff_req) begin
			pwroff_q <= 1'b1;
		end
	end

	// The requests feed in directly so devtbl drops its bits on the next edge.
	assign sys_rst_o = rst_p | warm_req | pwroff_req | pwroff_q | (cntr_q != '0);

endmodule

// File: hdl/soc_cfg_pkg.sv
// Fixed map of three device slots; anything outside devtbl and gpio falls to the invalid slot.
package soc_cfg_pkg;

	// Device slots, in the order the device table reports them.
	typedef enum logic [1:0] {
		SLOT_DEVTBL  = 2'd0,
		SLOT_GPIO    = 2'd1,
		SLOT_INVALID = 2'd2
	} slot_e;

	localparam int SLOT_COUNT = 3;

	// Address map in words.
	localparam logic [pi1_pkg::ADDR_W-1:0] DEVTBL_BASE = 8'd0;
	localparam logic [pi1_pkg::ADDR_W-1:0] DEVTBL_WORDS = 8'd16;
	localparam logic [pi1_pkg::ADDR_W-1:0] GPIO_BASE = 8'd16;
	localparam logic [pi1_pkg::ADDR_W-1:0] GPIO_WORDS = 8'd4;
	localparam logic [pi1_pkg::ADDR_W-1:0] INVALID_WORDS = 8'd64;

	// Device IDs as seen by software.
	localparam logic [pi1_pkg::ARCH_W-1:0] DEV_ID_DEVTBL = 32'd7;
	localparam logic [pi1_pkg::ARCH_W-1:0] DEV_ID_GPIO = 32'd6;
	localparam logic [pi1_pkg::ARCH_W-1:0] DEV_ID_INVALID = 32'd0;

	localparam logic [pi1_pkg::ARCH_W-1:0] SOC_ID = 32'd2;

	// Special words inside the device table.
	localparam logic [3:0] RST_CTRL_WORD = 4'd15;
	localparam logic [3:0] SOC_ID_WORD = 4'd14;

	function automatic logic [pi1_pkg::ARCH_W-1:0] slot_id(input slot_e slot);
		case (slot)
			SLOT_DEVTBL: slot_id = DEV_ID_DEVTBL;
			SLOT_GPIO: slot_id = DEV_ID_GPIO;
			default: slot_id = DEV_ID_INVALID;
		endcase
	endfunction

	function automatic logic [pi1_pkg::ADDR_W-1:0] slot_words(input slot_e slot);
		case (slot)
			SLOT_DEVTBL: slot_words = DEVTBL_WORDS;
			SLOT_GPIO: slot_words = GPIO_WORDS;
			default: slot_words = INVALID_WORDS;
		endcase
	endfunction

endpackage

// File: hdl/pi1_pkg.sv
// Single bus master, word addressed, every slave answers exactly one cycle after a request.
package pi1_pkg;

	// Data path width and the byte lanes that cover it.
	localparam int ARCH_W = 32;
	localparam int SEL_W = ARCH_W / 8;

	// Word address width, 256 words of map.
	localparam int ADDR_W = 8;

	// Bus opcodes.
	// A read-write returns the old word and stores the new one in the same transfer.
	typedef enum logic [1:0] {
		PI1_NONE   = 2'b00,
		PI1_WRONLY = 2'b01,
		PI1_RDONLY = 2'b10,
		PI1_RDWR   = 2'b11
	} pi1_op_e;

endpackage
